/* include/colmix_macros.svh */
// colour mixer widths, layer code sizes, blank pipeline depth and object palette bank
`ifndef COLMIX_MACROS_SVH
`define COLMIX_MACROS_SVH

// palette index, addresses all 256 colour entries
`define PAL_AW 8

// character and object pixel codes, 2 bits colour + 4 bits palette
`define CODE_W 6

// scroll pixel, top bit is the window flag
`define SCR_W 7

// colour nibble per channel
`define COL_W 4

// blanking delay in pixel enables, matches prio + palette latency
`define BLANK_STAGES 2

// objects live in the second quarter of the palette
`define OBJ_BANK 2'b01

`endif

/* verilog/video_pkg.sv */
// pixel side types for the colour mixer: layer pixels, blanking, colour and enables
`include "colmix_macros.svh"

package video_pkg;

    // one pixel from each of the three layer generators
    typedef struct packed {
        logic [`CODE_W-1:0] char_pxl;   // low 2 bits == 3 means transparent
        logic [`SCR_W-1:0]  scr_pxl;    // msb is window flag
        logic [`CODE_W-1:0] obj_pxl;    // low 4 bits all ones = blank
    } layer_pxl_t;

    // blanking flags, both active high
    typedef struct packed {
        logic hblank;
        logic vblank;
    } blank_t;

    // 12-bit output colour
    typedef struct packed {
        logic [`COL_W-1:0] red;
        logic [`COL_W-1:0] green;
        logic [`COL_W-1:0] blue;
    } rgb_t;

    // debug layer enables, static during a frame
    typedef struct packed {
        logic char_en;
        logic scr_en;
        logic obj_en;
    } layer_en_t;

    // red/green palette RAM word
    typedef struct packed {
        logic [`COL_W-1:0] red;
        logic [`COL_W-1:0] green;
    } rg_t;

endpackage

/* verilog/cpu_bus_pkg.sv */
// cpu side types for palette RAM writes
`include "colmix_macros.svh"

package cpu_bus_pkg;

    // which palette RAM a write goes to
    typedef enum logic {
        chan_rg = 1'b0,     // red/green byte
        chan_b  = 1'b1      // blue nibble, low half of data
    } pal_chan_t;

    // one palette write request, held by the cpu until accepted
    typedef struct packed {
        logic [`PAL_AW-1:0] addr;
        pal_chan_t          chan;
        logic [7:0]         data;   // blue uses data[3:0] only
    } pal_wr_t;

endpackage

/* verilog/layer_prio.sv */
// layer priority selector, picks char, object or scroll per pixel and registers the palette index
`timescale 1ns/10ps
`include "colmix_macros.svh"

module layer_prio (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  video_pkg::layer_pxl_t  layers,
    input  video_pkg::layer_en_t   layer_en,
    output logic [`PAL_AW-1:0]     pal_idx
);

    logic               char_opq;   // char pixel not transparent
    logic               obj_opq;    // object pixel not blank
    logic               scr_lift;   // window scroll pixel goes above objects
    logic [`PAL_AW-1:0] scr_idx;
    logic [`PAL_AW-1:0] nxt_idx;

    assign char_opq = layers.char_pxl[1:0] != 2'b11;   // colour 3 is see-through
    assign obj_opq  = ~&layers.obj_pxl[3:0];

    // window bit only lifts scroll colours other than 0 and 6
    assign scr_lift = layers.scr_pxl[`SCR_W-1]
                   && (layers.scr_pxl[2:0] != 3'd0)
                   && (layers.scr_pxl[2:0] != 3'd6);

    // scroll occupies the bottom 64 entries, disabled scroll reads entry 255
    assign scr_idx = layer_en.scr_en ? {2'b00, layers.scr_pxl[`SCR_W-2:0]} : '1;

    always_comb begin
        if (char_opq && layer_en.char_en) begin
            nxt_idx = {2'b11, layers.char_pxl};     // chars on top bank
        end else if (layer_en.obj_en && obj_opq && !scr_lift) begin
            nxt_idx = {`OBJ_BANK, layers.obj_pxl};
        end else begin
            nxt_idx = scr_idx;                      // scroll, or 255 when off
        end
    end

    // index changes only at pixel rate
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_idx <= '0;
        end else if (pxl_cen) begin
            pal_idx <= nxt_idx;
        end
    end

endmodule

/* verilog/blank_delay.sv */
// blanking flag shift register, lines hblank/vblank up with the colour pipeline
`timescale 1ns/10ps
`include "colmix_macros.svh"

module blank_delay (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  video_pkg::blank_t  blank_in,
    output video_pkg::blank_t  blank_first,    // first stage, same pixel as the palette index
    output video_pkg::blank_t  blank_out,      // last stage, same pixel as rgb
    output logic               vblank_now
);

    import video_pkg::*;

    blank_t sh [`BLANK_STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BLANK_STAGES; i++) begin
                sh[i] <= '1;    // blanked until the pipe fills
            end
        end else if (pxl_cen) begin
            sh[0] <= blank_in;
            for (int i = 1; i < `BLANK_STAGES; i++) begin
                sh[i] <= sh[i-1];
            end
        end
    end

    assign blank_first = sh[0];
    assign blank_out   = sh[`BLANK_STAGES-1];
    assign vblank_now  = sh[0].vblank;     // opens the cpu write window

endmodule

/* verilog/pal_ram.sv */
// dual-port palette RAM, one write port and a read port registered every clock
`timescale 1ns/10ps
`include "colmix_macros.svh"

module pal_ram #(
    parameter type T = logic [7:0]      // payload, rg byte or blue nibble
) (
    input  logic               clk,
    input  logic [`PAL_AW-1:0] rd_addr,
    input  logic [`PAL_AW-1:0] wr_addr,
    input  logic               we,
    input  T                   wr_data,
    output T                   rd_data
);

    T mem [1 << `PAL_AW];   // contents undefined until the cpu fills them

    // write side, cpu clocked
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read every clock so data settles between pixel enables
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/pal_write.sv */
// cpu palette write port, valid/ready, accepts only in vertical blank and steers to rg or blue RAM
`timescale 1ns/10ps
`include "colmix_macros.svh"

module pal_write (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  vblank_now,
    input  cpu_bus_pkg::pal_wr_t  wr_req,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    output logic [`PAL_AW-1:0]    wr_addr,
    output logic                  rg_we,
    output video_pkg::rg_t        rg_data,
    output logic                  b_we,
    output logic [`COL_W-1:0]     b_data
);

    import cpu_bus_pkg::*;

    logic acc_q;    // a request was taken on the last edge
    logic hs;       // handshake this clock

    // ready follows the latched vblank, dropped for one clock after each accept
    // so a request still held on the accepting edge is not written twice
    assign wr_ready = vblank_now && !acc_q;
    assign hs       = wr_valid && wr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= 1'b1;      // keeps ready low through reset
        end else begin
            acc_q <= hs;
        end
    end

    assign wr_addr = wr_req.addr;  // shared by both RAMs

    // exactly one RAM sees the write
    assign rg_we = hs && (wr_req.chan == chan_rg);
    assign b_we  = hs && (wr_req.chan == chan_b);

    assign rg_data = wr_req.data;             // red high nibble, green low
    assign b_data  = wr_req.data[`COL_W-1:0]; // blue always from the low nibble

endmodule

/* verilog/colmix_top.sv */
// colour mixer top, layer priority into palette RAMs with blank-aligned registered colour out
`timescale 1ns/10ps
`include "colmix_macros.svh"

module colmix_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  video_pkg::layer_pxl_t  layers,
    input  video_pkg::layer_en_t   layer_en,
    input  video_pkg::blank_t      blank_in,
    input  cpu_bus_pkg::pal_wr_t   wr_req,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    output video_pkg::rgb_t        rgb,
    output video_pkg::blank_t      blank_out
);

    import video_pkg::*;

    logic [`PAL_AW-1:0] pal_idx;    // registered at pixel edge n
    logic [`PAL_AW-1:0] wr_addr;
    logic               rg_we;
    logic               b_we;
    rg_t                rg_data;
    logic [`COL_W-1:0]  b_data;
    rg_t                rg_q;       // valid one clock after pal_idx
    logic [`COL_W-1:0]  b_q;
    blank_t             blank_first;
    logic               vblank_now;

    layer_prio u_prio (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .layers   (layers),
        .layer_en (layer_en),
        .pal_idx  (pal_idx)
    );

    blank_delay u_blank (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .blank_in    (blank_in),
        .blank_first (blank_first),
        .blank_out   (blank_out),
        .vblank_now  (vblank_now)
    );

    pal_write u_wr (
        .clk        (clk),
        .rst        (rst),
        .vblank_now (vblank_now),
        .wr_req     (wr_req),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .wr_addr    (wr_addr),
        .rg_we      (rg_we),
        .rg_data    (rg_data),
        .b_we       (b_we),
        .b_data     (b_data)
    );

    // red/green byte per palette entry
    pal_ram #(.T(rg_t)) u_rg_ram (
        .clk     (clk),
        .rd_addr (pal_idx),
        .wr_addr (wr_addr),
        .we      (rg_we),
        .wr_data (rg_data),
        .rd_data (rg_q)
    );

    // blue nibble per palette entry
    pal_ram #(.T(logic [`COL_W-1:0])) u_b_ram (
        .clk     (clk),
        .rd_addr (pal_idx),
        .wr_addr (wr_addr),
        .we      (b_we),
        .wr_data (b_data),
        .rd_data (b_q)
    );

    // output colour at pixel edge n+1, black while the pixel's blank is set
    // blank_first holds that pixel's flags here, they move to blank_out on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (blank_first.hblank || blank_first.vblank) begin
                rgb <= '0;
            end else begin
                rgb <= {rg_q.red, rg_q.green, b_q};
            end
        end
    end

endmodule

/* bench/colmix_properties.sv */
// colour mixer assertions, reset state, black output in blanking and cpu write gating
`timescale 1ns/10ps

module colmix_properties (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  logic               wr_ready,
    input  logic               vblank_now,
    input  logic               rg_we,
    input  logic               b_we,
    input  video_pkg::rgb_t    rgb,
    input  video_pkg::blank_t  blank_out
);

    int fails = 0;  // failed assertion count, summed into the closing status

    // port is closed on the clock after every reset edge
    ready_low_in_reset: assert property (@(posedge clk) rst |=> !wr_ready)
        else begin
            $error("wr_ready high on the clock after a reset edge");
            fails++;
        end

    // rgb and blank_out load on the same pixel enable
    black_in_blank: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> (!(|blank_out) || (rgb == '0)))
        else begin
            $error("rgb not black while blank_out shows blanking");
            fails++;
        end

    // palette only changes while the latched vblank is set
    write_only_in_vblank: assert property (@(posedge clk) disable iff (rst)
        !vblank_now |-> !(rg_we || b_we))
        else begin
            $error("palette write enable active outside vertical blank");
            fails++;
        end

endmodule

bind colmix_top colmix_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .pxl_cen    (pxl_cen),
    .wr_ready   (wr_ready),
    .vblank_now (vblank_now),
    .rg_we      (rg_we),
    .b_we       (b_we),
    .rgb        (rgb),
    .blank_out  (blank_out)
);

/* bench/colmix_checker.sv */
// colour mixer reference model, predicts each output pixel and compares rgb and blank_out
`timescale 1ns/10ps
`include "colmix_macros.svh"

module colmix_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  video_pkg::layer_pxl_t  layers,
    input  video_pkg::layer_en_t   layer_en,
    input  video_pkg::blank_t      blank_in,
    input  cpu_bus_pkg::pal_wr_t   wr_req,
    input  logic                   wr_valid,
    input  logic                   wr_ready,
    input  video_pkg::rgb_t        rgb,
    input  video_pkg::blank_t      blank_out,
    output int                     errors,
    output int                     checked
);

    import video_pkg::*;
    import cpu_bus_pkg::*;

    typedef enum {win_char, win_obj, win_scroll, win_window, win_off} win_t;

    logic [`COL_W-1:0] red_m   [1 << `PAL_AW];  // model palette, one array per channel
    logic [`COL_W-1:0] green_m [1 << `PAL_AW];
    logic [`COL_W-1:0] blue_m  [1 << `PAL_AW];

    logic               s1_vld;     // pixel sampled on the last enable
    logic [`PAL_AW-1:0] s1_idx;
    blank_t             s1_blank;
    string              s1_name;
    logic               s2_vld;     // pixel whose colour is in rgb now
    rgb_t               s2_rgb;
    blank_t             s2_blank;
    string              s2_name;
    logic               vb_latched; // vblank as of the last pixel enable

    // layer that should show for one pixel
    function automatic win_t winner(layer_pxl_t p, layer_en_t en);
        logic chr_solid;
        logic obj_solid;
        logic window_up;
        chr_solid = (p.char_pxl[1:0] != 2'd3);
        obj_solid = (p.obj_pxl[3:0] != 4'hf);
        window_up = p.scr_pxl[`SCR_W-1] && !(p.scr_pxl[2:0] inside {3'd0, 3'd6});
        if (en.char_en && chr_solid) return win_char;
        if (en.obj_en && obj_solid && !window_up) return win_obj;
        if (!en.scr_en) return win_off;         // nothing left, entry 255
        if (en.obj_en && obj_solid) return win_window;
        return win_scroll;
    endfunction

    function automatic logic [`PAL_AW-1:0] index_of(win_t w, layer_pxl_t p);
        case (w)
            win_char: return {2'b11, p.char_pxl};
            win_obj:  return {`OBJ_BANK, p.obj_pxl};
            win_off:  return '1;
            default:  return {2'b00, p.scr_pxl[5:0]};
        endcase
    endfunction

    always @(posedge clk) begin
        win_t w;
        if (rst) begin
            s1_vld     = 1'b0;
            s2_vld     = 1'b0;
            vb_latched = 1'b1;
            errors     = 0;
            checked    = 0;
        end else begin
            if (wr_ready && !vb_latched) begin
                errors++;
                $display("write port ready outside vertical blank at %0t", $time);
            end
            if (pxl_cen) begin
                if (s2_vld) begin
                    checked++;
                    if (rgb !== s2_rgb) begin
                        errors++;
                        $display("Mismatch %s: rgb expected %03h actual %03h at %0t",
                                 s2_name, s2_rgb, rgb, $time);
                    end
                    if (blank_out !== s2_blank) begin
                        errors++;
                        $display("Mismatch blank_delay: blank_out expected %b actual %b at %0t",
                                 s2_blank, blank_out, $time);
                    end
                end
                // palette read before any write taken on this edge
                s2_vld   = s1_vld;
                s2_blank = s1_blank;
                s2_name  = s1_name;
                if (s1_blank.hblank || s1_blank.vblank) begin
                    s2_rgb = '0;
                end else begin
                    s2_rgb = {red_m[s1_idx], green_m[s1_idx], blue_m[s1_idx]};
                end
                w          = winner(layers, layer_en);
                s1_vld     = 1'b1;
                s1_idx     = index_of(w, layers);
                s1_blank   = blank_in;
                s1_name    = (blank_in.hblank || blank_in.vblank) ? "blanking" : w.name();
                vb_latched = blank_in.vblank;
            end
            // model changes only on a completed handshake
            if (wr_valid && wr_ready) begin
                if (wr_req.chan == chan_rg) begin
                    red_m[wr_req.addr]   = wr_req.data[7:4];
                    green_m[wr_req.addr] = wr_req.data[3:0];
                end else begin
                    blue_m[wr_req.addr] = wr_req.data[3:0];  // high nibble ignored
                end
            end
        end
    end

endmodule

/* bench/colmix_tb.sv */
// colour mixer testbench, seeded random frames with palette writes against the checker model
`timescale 1ns/10ps
`include "colmix_macros.svh"

module colmix_tb;

    import video_pkg::*;
    import cpu_bus_pkg::*;

    localparam int unsigned seed = 32'h1b91_3627;
    localparam int n_frames  = 6;
    localparam int vb_pix    = 160;     // vertical blank per frame, in pixels
    localparam int lines     = 6;
    localparam int line_pix  = 24;
    localparam int hb_pix    = 4;
    localparam int frame_pix = vb_pix + lines * (line_pix + hb_pix);
    localparam int held_clks = 2 * line_pix;    // a wait this long spans active video
    // fill phase counted as one more frame, 4 clocks per pixel at most, then margin 2
    localparam int watchdog_clks = (n_frames + 1) * frame_pix * 4 * 2;
    localparam blank_t blank_none = '{hblank: 1'b0, vblank: 1'b0};
    localparam blank_t blank_h    = '{hblank: 1'b1, vblank: 1'b0};
    localparam blank_t blank_v    = '{hblank: 1'b0, vblank: 1'b1};

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    layer_pxl_t layers;
    layer_en_t  layer_en;
    blank_t     blank_in;
    pal_wr_t    wr_req;
    logic       wr_valid;
    logic       wr_ready;
    rgb_t       rgb;
    blank_t     blank_out;
    int         chk_errors;
    int         checked;
    int         gap;        // clocks per pixel, fixed within a frame
    logic       fill_done;
    int         writes;
    int         held;       // writes that waited through active video
    int         tb_errors;

    always #2 clk = ~clk;

    colmix_top colmix_top_i (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .layers(layers), .layer_en(layer_en),
        .blank_in(blank_in), .wr_req(wr_req), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .rgb(rgb), .blank_out(blank_out)
    );

    colmix_checker u_checker (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .layers(layers), .layer_en(layer_en),
        .blank_in(blank_in), .wr_req(wr_req), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .rgb(rgb), .blank_out(blank_out), .errors(chk_errors), .checked(checked)
    );

    function automatic layer_pxl_t random_pixel();
        layer_pxl_t p;
        logic [31:0] r;
        r = $urandom();
        p.char_pxl = r[5:0];
        p.scr_pxl  = r[12:6];
        p.obj_pxl  = r[18:13];
        if (r[19]) p.char_pxl[1:0] = 2'b11;                 // see-through char, half the time
        if (r[21:20] == 2'd0) p.obj_pxl[3:0] = 4'hf;        // blank object
        if (r[24:22] == 3'd0) p.scr_pxl[2:0] = r[25] ? 3'd0 : 3'd6;  // window cannot lift
        return p;
    endfunction

    // pxl_cen on the first clock of the pixel, idle for the rest of the gap
    task automatic drive_pixel(input layer_pxl_t p, input blank_t b);
        pxl_cen  = 1'b1;
        layers   = p;
        blank_in = b;
        @(posedge clk);
        #1;
        pxl_cen = 1'b0;
        repeat (gap - 1) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds one request until the handshake edge
    task automatic send_write(input pal_wr_t req);
        logic taken;
        int   waited;
        wr_req   = req;
        wr_valid = 1'b1;
        taken    = 1'b0;
        waited   = 0;
        while (!taken) begin
            taken = wr_ready;   // settled since the last edge, decides the next one
            @(posedge clk);
            #1;
            if (!taken) waited++;
        end
        wr_valid = 1'b0;
        writes++;
        if (waited > held_clks) held++;
    endtask

    task automatic run_cpu();
        pal_wr_t     req;
        logic [31:0] r;
        // both channels of all 256 entries before any visible pixel
        for (int i = 0; i < (1 << `PAL_AW); i++) begin
            r        = $urandom();
            req.addr = i[`PAL_AW-1:0];
            req.chan = chan_rg;
            req.data = r[7:0];
            send_write(req);
            req.chan = chan_b;
            req.data = r[15:8];     // high nibble is don't-care
            send_write(req);
        end
        fill_done = 1'b1;
        forever begin
            r = $urandom();
            repeat (r[3:0]) begin
                @(posedge clk);
                #1;
            end
            req.addr = r[15:8];
            req.chan = pal_chan_t'(r[16]);
            req.data = r[31:24];
            send_write(req);
        end
    endtask

    task automatic run_video();
        logic [31:0] r;
        while (!fill_done) drive_pixel(random_pixel(), blank_v);
        for (int f = 0; f < n_frames; f++) begin
            r        = $urandom();
            gap      = 2 + int'(r % 3);
            // first frame all layers on, last frame all off
            layer_en = (f == 0) ? 3'b111 : ((f == n_frames - 1) ? 3'b000 : r[10:8]);
            repeat (vb_pix) drive_pixel(random_pixel(), blank_v);
            for (int l = 0; l < lines; l++) begin
                repeat (line_pix) drive_pixel(random_pixel(), blank_none);
                repeat (hb_pix) drive_pixel(random_pixel(), blank_h);
            end
        end
        repeat (4) drive_pixel(random_pixel(), blank_v);    // flush the colour pipe
    endtask

    initial begin
        void'($urandom(seed));
        clk       = 1'b0;
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        layers    = '0;
        layer_en  = 3'b111;
        blank_in  = blank_v;
        wr_req    = '0;
        wr_valid  = 1'b0;
        gap       = 2;
        fill_done = 1'b0;
        writes    = 0;
        held      = 0;
        tb_errors = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            run_cpu();
        join_none
        run_video();
        @(negedge clk);
        if (held == 0) begin
            tb_errors++;
            $display("no palette write was held back through active video");
        end
        $display("checker errors %0d, bench errors %0d, assertion failures %0d, pixels %0d, writes %0d",
                 chk_errors, tb_errors, colmix_top_i.u_props.fails, checked, writes);
        if (chk_errors + tb_errors + colmix_top_i.u_props.fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_clks) @(posedge clk);
        $display("timeout, run still busy after %0d clocks", watchdog_clks);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
verilog/video_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/layer_prio.sv
verilog/blank_delay.sv
verilog/pal_ram.sv
verilog/pal_write.sv
verilog/colmix_top.sv
bench/colmix_properties.sv
bench/colmix_checker.sv
bench/colmix_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = colmix_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
